// File: list.f
+incdir+tb
common/rv_pkg.sv
common/dmem_if.sv
core/rv_decoder.sv
core/rv_alu.sv
core/rv_regfile.sv
core/rv_hazard.sv
core/rv_core.sv
logic/rv_imem.sv
logic/rv_dmem.sv
logic/rv_soc.sv
tb/tb_rv_soc.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" \
	&& verilator --binary --timing -f list.f --top-module tb_rv_soc -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -qx "No errors" sim.log \
	|| { echo "Simulation failed"; exit 1; }
echo "Simulation passed"

// File: tb/rv_tb_model.svh
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

// ==============================
// Program store and model state
// ==============================
localparam int PROG_LEN  = 120;
localparam int DATA_BASE = 256;
// Bytes of data window behind the base register
localparam int DATA_SPAN = 32;

localparam int K_ADD  = 0;
localparam int K_SUB  = 1;
localparam int K_AND  = 2;
localparam int K_OR   = 3;
localparam int K_XOR  = 4;
localparam int K_SLT  = 5;
localparam int K_ADDI = 6;
localparam int K_ANDI = 7;
localparam int K_ORI  = 8;
localparam int K_XORI = 9;
localparam int K_LUI  = 10;
localparam int K_LW   = 11;
localparam int K_LB   = 12;
localparam int K_LBU  = 13;
localparam int K_SW   = 14;
localparam int K_SB   = 15;
localparam int K_BEQ  = 16;
localparam int K_BNE  = 17;
localparam int K_BLT  = 18;
localparam int K_BGE  = 19;
localparam int K_JAL  = 20;

int          prog_kind [PROG_LEN];
logic [4:0]  prog_rd   [PROG_LEN];
logic [4:0]  prog_rs1  [PROG_LEN];
logic [4:0]  prog_rs2  [PROG_LEN];
logic [31:0] prog_imm  [PROG_LEN];
logic [31:0] prog_word [PROG_LEN];

logic [31:0] mreg  [32];
logic [7:0]  mbyte [DATA_SPAN];

// Expected retirements, oldest first
logic [4:0]  exp_rd [$];
logic [31:0] exp_data [$];

// Instruction formats from the ISA manual
function automatic logic [31:0] encode_inst(int kind, logic [4:0] rd, logic [4:0] rs1,
	logic [4:0] rs2, logic [31:0] imm);
	case (kind)
		K_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
		K_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
		K_AND:  return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
		K_OR:   return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
		K_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
		K_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
		K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
		K_ANDI: return {imm[11:0], rs1, 3'b111, rd, 7'b0010011};
		K_ORI:  return {imm[11:0], rs1, 3'b110, rd, 7'b0010011};
		K_XORI: return {imm[11:0], rs1, 3'b100, rd, 7'b0010011};
		K_LUI:  return {imm[31:12], rd, 7'b0110111};
		K_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
		K_LB:   return {imm[11:0], rs1, 3'b000, rd, 7'b0000011};
		K_LBU:  return {imm[11:0], rs1, 3'b100, rd, 7'b0000011};
		K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
		K_SB:   return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
		K_BEQ, K_BNE, K_BLT, K_BGE:
			return {imm[12], imm[10:5], rs2, rs1,
				(kind == K_BEQ) ? 3'b000 : (kind == K_BNE) ? 3'b001 :
				(kind == K_BLT) ? 3'b100 : 3'b101,
				imm[4:1], imm[11], 7'b1100011};
		default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endcase
endfunction

task automatic put_inst(int idx, int kind, logic [4:0] rd, logic [4:0] rs1,
	logic [4:0] rs2, logic [31:0] imm);
	prog_kind[idx] = kind;
	prog_rd[idx]   = rd;
	prog_rs1[idx]  = rs1;
	prog_rs2[idx]  = rs2;
	prog_imm[idx]  = imm;
	prog_word[idx] = encode_inst(kind, rd, rs1, rs2, imm);
endtask

// ==============================
// Random program generator
// ==============================
task automatic gen_program();
	int          pick;
	int          kind;
	int          hop;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [31:0] imm;
	// Base register x1, then clear the data window
	put_inst(0, K_ADDI, 5'd1, 5'd0, 5'd0, DATA_BASE);
	for (int k = 0; k < 8; k++)
		put_inst(k + 1, K_SW, 5'd0, 5'd1, 5'd0, 32'(4 * k));
	for (int idx = 9; idx < PROG_LEN - 1; idx++)
	begin
		pick = int'($urandom % 100);
		// Small register pool keeps dependencies dense, x1 never overwritten
		rd   = 5'(2 + $urandom % 6);
		rs1  = 5'($urandom % 8);
		rs2  = 5'($urandom % 8);
		imm  = 32'(int'($urandom % 4096) - 2048);
		if (pick < 30)
			kind = int'($urandom % 6);
		else if (pick < 50)
			kind = K_ADDI + int'($urandom % 4);
		else if (pick < 55)
		begin
			kind = K_LUI;
			imm  = $urandom & 32'hffff_f000;
		end
		else if (pick < 70)
		begin
			kind = K_LW + int'($urandom % 3);
			rs1  = 5'd1;
			imm  = (kind == K_LW) ? 32'(4 * ($urandom % 8)) : 32'($urandom % DATA_SPAN);
		end
		else if (pick < 80)
		begin
			kind = K_SW + int'($urandom % 2);
			rs1  = 5'd1;
			imm  = (kind == K_SW) ? 32'(4 * ($urandom % 8)) : 32'($urandom % DATA_SPAN);
		end
		else
		begin
			// Forward only, never past the closing self loop
			kind = (pick < 92) ? K_BEQ + int'($urandom % 4) : K_JAL;
			hop  = 1 + int'($urandom % 5);
			if (idx + hop > PROG_LEN - 1)
				hop = PROG_LEN - 1 - idx;
			imm = 32'(4 * hop);
		end
		put_inst(idx, kind, rd, rs1, rs2, imm);
	end
	put_inst(PROG_LEN - 1, K_JAL, 5'd0, 5'd0, 5'd0, 32'd0);
endtask

// ==============================
// Sequential reference model
// ==============================
task automatic write_reg(logic [4:0] rd, logic [31:0] val);
	if (rd != 5'd0)
	begin
		mreg[rd] = val;
		exp_rd.push_back(rd);
		exp_data.push_back(val);
	end
endtask

task automatic run_model();
	int          idx;
	int          ofs;
	int          steps;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] wd;
	logic        jump;
	for (int r = 0; r < 32; r++)
		mreg[r] = '0;
	for (int k = 0; k < DATA_SPAN; k++)
		mbyte[k] = '0;
	exp_rd.delete();
	exp_data.delete();
	idx   = 0;
	steps = 0;
	while (idx != PROG_LEN - 1 && steps < 1000)
	begin
		a    = mreg[prog_rs1[idx]];
		b    = mreg[prog_rs2[idx]];
		ofs  = int'(a + prog_imm[idx]) - DATA_BASE;
		jump = 1'b0;
		case (prog_kind[idx])
			K_ADD:  write_reg(prog_rd[idx], a + b);
			K_SUB:  write_reg(prog_rd[idx], a - b);
			K_AND:  write_reg(prog_rd[idx], a & b);
			K_OR:   write_reg(prog_rd[idx], a | b);
			K_XOR:  write_reg(prog_rd[idx], a ^ b);
			K_SLT:  write_reg(prog_rd[idx], {31'b0, $signed(a) < $signed(b)});
			K_ADDI: write_reg(prog_rd[idx], a + prog_imm[idx]);
			K_ANDI: write_reg(prog_rd[idx], a & prog_imm[idx]);
			K_ORI:  write_reg(prog_rd[idx], a | prog_imm[idx]);
			K_XORI: write_reg(prog_rd[idx], a ^ prog_imm[idx]);
			K_LUI:  write_reg(prog_rd[idx], prog_imm[idx]);
			K_LW:
			begin
				wd = {mbyte[ofs + 3], mbyte[ofs + 2], mbyte[ofs + 1], mbyte[ofs]};
				write_reg(prog_rd[idx], wd);
			end
			K_LB:   write_reg(prog_rd[idx], {{24{mbyte[ofs][7]}}, mbyte[ofs]});
			K_LBU:  write_reg(prog_rd[idx], {24'b0, mbyte[ofs]});
			K_SW:
			begin
				for (int k = 0; k < 4; k++)
					mbyte[ofs + k] = b[8*k +: 8];
			end
			K_SB:   mbyte[ofs] = b[7:0];
			K_BEQ:  jump = (a == b);
			K_BNE:  jump = (a != b);
			K_BLT:  jump = $signed(a) < $signed(b);
			K_BGE:  jump = $signed(a) >= $signed(b);
			default:
			begin
				// Link is the byte address after the JAL
				write_reg(prog_rd[idx], 32'(4 * idx + 4));
				jump = 1'b1;
			end
		endcase
		idx = jump ? idx + int'(prog_imm[idx]) / 4 : idx + 1;
		steps++;
	end
endtask

`endif

// File: tb/tb_rv_soc.sv
`timescale 1ns/1ns

module tb_rv_soc;

	// Each program budgeted 6 cycles per instruction plus slack
	localparam int  NUM_PROGS   = 4;
	localparam time WATCHDOG_NS = NUM_PROGS * (120 * 6 + 60) * 10;

	logic        clk;
	logic        rst_n;
	logic        i_halt;
	logic        i_imem_we;
	logic [7:0]  i_imem_addr;
	logic [31:0] i_imem_wdata;
	logic        o_wb_valid;
	logic [4:0]  o_wb_rd;
	logic [31:0] o_wb_data;

	int          errors;
	int          checked;
	int          halt_left;
	logic        halt_en;
	string       test_name;

	`include "rv_tb_model.svh"

	rv_soc i_rv_soc
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.i_halt       (i_halt),
		.i_imem_we    (i_imem_we),
		.i_imem_addr  (i_imem_addr),
		.i_imem_wdata (i_imem_wdata),
		.o_wb_valid   (o_wb_valid),
		.o_wb_rd      (o_wb_rd),
		.o_wb_data    (o_wb_data)
	);

	initial
		clk = 1'b0;
	always #5 clk = ~clk;

	// ==============================
	// Random halt bursts
	// ==============================
	always @(posedge clk)
	begin
		#1;
		if (!halt_en)
		begin
			i_halt    = 1'b0;
			halt_left = 0;
		end
		else if (halt_left > 0)
		begin
			i_halt = 1'b1;
			halt_left--;
		end
		else if ($urandom % 10 == 0)
		begin
			// Burst of 1 to 5 cycles
			i_halt    = 1'b1;
			halt_left = int'($urandom % 5);
		end
		else
			i_halt = 1'b0;
	end

	// ==============================
	// Retirement checker
	// ==============================
	// Sampled mid-cycle when outputs are settled
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (i_halt && o_wb_valid)
			begin
				$display("%s: retirement strobe seen while halt was high", test_name);
				errors++;
			end
			if (o_wb_valid)
			begin
				if (exp_rd.size() == 0)
				begin
					$display("%s: unexpected retirement of x%0d", test_name, o_wb_rd);
					errors++;
				end
				else
				begin
					if (o_wb_rd != exp_rd[0])
					begin
						$display("Mismatch %s rd: expected x%0d, actual x%0d",
							test_name, exp_rd[0], o_wb_rd);
						errors++;
					end
					if (o_wb_data != exp_data[0])
					begin
						$display("Mismatch %s x%0d data: expected %08h, actual %08h",
							test_name, exp_rd[0], exp_data[0], o_wb_data);
						errors++;
					end
					void'(exp_rd.pop_front());
					void'(exp_data.pop_front());
					checked++;
				end
			end
		end
	end

	// Program goes in while the core sits in reset
	task automatic load_and_reset();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		for (int k = 0; k < PROG_LEN; k++)
		begin
			@(posedge clk);
			#1;
			i_imem_we    = 1'b1;
			i_imem_addr  = 8'(k);
			i_imem_wdata = prog_word[k];
		end
		@(posedge clk);
		#1;
		i_imem_we = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic wait_drain();
		while (exp_rd.size() != 0)
			@(posedge clk);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial
	begin
		void'($urandom(19815));
		rst_n        = 1'b0;
		i_halt       = 1'b0;
		i_imem_we    = 1'b0;
		i_imem_addr  = '0;
		i_imem_wdata = '0;
		halt_en      = 1'b0;
		halt_left    = 0;
		errors       = 0;
		checked      = 0;
		test_name    = "idle";
		for (int p = 0; p < NUM_PROGS; p++)
		begin
			gen_program();
			run_model();
			test_name = $sformatf("prog%0d", p);
			load_and_reset();
			// Bursts enabled on the edge, ahead of the halt driver
			@(posedge clk);
			halt_en = 1'b1;
			wait_drain();
			halt_en = 1'b0;
			// Any strobe in the quiet window is a stray write
			repeat (20) @(posedge clk);
		end
		$display("Summary: %0d errors, %0d retirements checked", errors, checked);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: %s did not retire all expected writes in time", test_name);
		$display("Errors found");
		$finish;
	end

endmodule

// File: logic/rv_soc.sv
`timescale 1ns/1ns

module rv_soc
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       i_halt,
	input  logic                       i_imem_we,
	input  logic [rv_pkg::IMEM_AW-1:0] i_imem_addr,
	input  logic [rv_pkg::XLEN-1:0]    i_imem_wdata,
	output logic                       o_wb_valid,
	output logic [4:0]                 o_wb_rd,
	output logic [rv_pkg::XLEN-1:0]    o_wb_data
);

	logic [rv_pkg::XLEN-1:0] pc;
	logic [rv_pkg::XLEN-1:0] inst;

	// Memory stage to data array
	dmem_if dmem_bus ();

	rv_core i_core
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.i_halt     (i_halt),
		.i_inst     (inst),
		.o_pc       (pc),
		.dmem       (dmem_bus.core),
		.o_wb_valid (o_wb_valid),
		.o_wb_rd    (o_wb_rd),
		.o_wb_data  (o_wb_data)
	);

	// Loadable during reset
	rv_imem i_imem
	(
		.clk     (clk),
		.i_we    (i_imem_we),
		.i_waddr (i_imem_addr),
		.i_wdata (i_imem_wdata),
		.i_pc    (pc),
		.o_inst  (inst)
	);

	rv_dmem i_dmem
	(
		.clk (clk),
		.bus (dmem_bus.mem)
	);

endmodule

// File: logic/rv_dmem.sv
`timescale 1ns/1ns

module rv_dmem
(
	input  logic clk,
	dmem_if.mem  bus
);

	logic [rv_pkg::XLEN-1:0]    mem [rv_pkg::DMEM_DEPTH];
	logic [rv_pkg::DMEM_AW-1:0] idx;
	logic [4:0]                 lane_lsb;
	logic [rv_pkg::XLEN-1:0]    word;
	logic [7:0]                 lane_byte;

	assign idx      = bus.addr[rv_pkg::DMEM_AW+1:2];
	// Bit offset of the addressed byte
	assign lane_lsb = {bus.addr[1:0], 3'b000};

	// ==============================
	// Store
	// ==============================
	always_ff @(posedge clk)
	begin
		if (bus.we)
		begin
			if (bus.size == rv_pkg::SZ_WORD)
				mem[idx] <= bus.wdata;
			else
				mem[idx][lane_lsb +: 8] <= bus.wdata[7:0];
		end
	end

	// ==============================
	// Load
	// ==============================
	assign word      = mem[idx];
	assign lane_byte = word[lane_lsb +: 8];

	always_comb
	begin
		if (!bus.re)
			bus.rdata = '0;
		else if (bus.size == rv_pkg::SZ_WORD)
			bus.rdata = word;
		else if (bus.is_unsigned)
			bus.rdata = {24'b0, lane_byte};
		else
			bus.rdata = {{24{lane_byte[7]}}, lane_byte};
	end

endmodule

// File: logic/rv_imem.sv
`timescale 1ns/1ns

module rv_imem
(
	input  logic                       clk,
	input  logic                       i_we,
	input  logic [rv_pkg::IMEM_AW-1:0] i_waddr,
	input  logic [rv_pkg::XLEN-1:0]    i_wdata,
	input  logic [rv_pkg::XLEN-1:0]    i_pc,
	output logic [rv_pkg::XLEN-1:0]    o_inst
);

	logic [rv_pkg::XLEN-1:0] mem [rv_pkg::IMEM_DEPTH];

	// Load port, word addressed
	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// Fetch ignores the byte offset
	assign o_inst = mem[i_pc[rv_pkg::IMEM_AW+1:2]];

endmodule

// File: core/rv_core.sv
`timescale 1ns/1ns

module rv_core
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_halt,
	input  logic [rv_pkg::XLEN-1:0] i_inst,
	output logic [rv_pkg::XLEN-1:0] o_pc,
	dmem_if.core                    dmem,
	output logic                    o_wb_valid,
	output logic [4:0]              o_wb_rd,
	output logic [rv_pkg::XLEN-1:0] o_wb_data
);

	logic [rv_pkg::XLEN-1:0] pc_q;
	rv_pkg::if_id_t          if_id_q;
	rv_pkg::id_ex_t          id_ex_q;
	rv_pkg::id_ex_t          id_ex_d;
	rv_pkg::ex_mem_t         ex_mem_q;
	rv_pkg::ex_mem_t         ex_mem_d;
	rv_pkg::mem_wb_t         mem_wb_q;
	rv_pkg::mem_wb_t         mem_wb_d;

	// Decode outputs
	logic [4:0]              dec_rs1;
	logic [4:0]              dec_rs2;
	logic [4:0]              dec_rd;
	logic [rv_pkg::XLEN-1:0] dec_imm;
	rv_pkg::ctrl_t           dec_ctrl;
	logic [rv_pkg::XLEN-1:0] rf_rdata1;
	logic [rv_pkg::XLEN-1:0] rf_rdata2;

	// Execute datapath
	rv_pkg::fwd_sel_e        fwd_a;
	rv_pkg::fwd_sel_e        fwd_b;
	logic [rv_pkg::XLEN-1:0] opnd_a;
	logic [rv_pkg::XLEN-1:0] rs2_fwd;
	logic [rv_pkg::XLEN-1:0] opnd_b;
	logic [rv_pkg::XLEN-1:0] alu_result;
	logic [rv_pkg::XLEN-1:0] target;
	logic                    taken;
	logic                    stall;
	logic                    flush;

	// Write-back
	logic                    wb_we;
	logic [rv_pkg::XLEN-1:0] wb_data;

	// ==============================
	// Fetch
	// ==============================
	// Halt over redirect over load-use hold
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc_q <= rv_pkg::RESET_PC;
		else if (!i_halt)
		begin
			if (flush)
				pc_q <= target;
			else if (!stall)
				pc_q <= pc_q + rv_pkg::INST_BYTES;
		end
	end

	assign o_pc = pc_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			if_id_q <= rv_pkg::IF_ID_NOP;
		else if (!i_halt)
		begin
			// Wrong path squashed
			if (flush)
				if_id_q <= rv_pkg::IF_ID_NOP;
			else if (!stall)
				if_id_q <= '{pc: pc_q, inst: i_inst};
		end
	end

	// ==============================
	// Decode
	// ==============================
	rv_decoder i_decoder
	(
		.i_inst (if_id_q.inst),
		.o_rs1  (dec_rs1),
		.o_rs2  (dec_rs2),
		.o_rd   (dec_rd),
		.o_imm  (dec_imm),
		.o_ctrl (dec_ctrl)
	);

	// Written from write-back, bypassed into decode reads
	rv_regfile i_regfile
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.i_rs1    (dec_rs1),
		.i_rs2    (dec_rs2),
		.i_we     (wb_we),
		.i_rd     (mem_wb_q.rd),
		.i_wdata  (wb_data),
		.o_rdata1 (rf_rdata1),
		.o_rdata2 (rf_rdata2)
	);

	rv_hazard i_hazard
	(
		.i_id_rs1  (dec_rs1),
		.i_id_rs2  (dec_rs2),
		.i_ex_rs1  (id_ex_q.rs1),
		.i_ex_rs2  (id_ex_q.rs2),
		.i_ex_rd   (id_ex_q.rd),
		.i_ex_load (id_ex_q.ctrl.mem_re),
		.i_mem_rd  (ex_mem_q.rd),
		.i_mem_we  (ex_mem_q.ctrl.reg_we),
		.i_wb_rd   (mem_wb_q.rd),
		.i_wb_we   (mem_wb_q.ctrl.reg_we),
		.i_taken   (taken),
		.o_fwd_a   (fwd_a),
		.o_fwd_b   (fwd_b),
		.o_stall   (stall),
		.o_flush   (flush)
	);

	assign id_ex_d = '{pc: if_id_q.pc, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
		rdata1: rf_rdata1, rdata2: rf_rdata2, imm: dec_imm, ctrl: dec_ctrl};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			id_ex_q <= rv_pkg::ID_EX_NOP;
		else if (!i_halt)
		begin
			// Bubble on squash or load-use
			if (flush || stall)
				id_ex_q <= rv_pkg::ID_EX_NOP;
			else
				id_ex_q <= id_ex_d;
		end
	end

	// ==============================
	// Execute
	// ==============================
	// Memory stage wins over write-back
	always_comb
	begin
		case (fwd_a)
			rv_pkg::FWD_MEM: opnd_a = ex_mem_q.result;
			rv_pkg::FWD_WB:  opnd_a = wb_data;
			default:         opnd_a = id_ex_q.rdata1;
		endcase
		case (fwd_b)
			rv_pkg::FWD_MEM: rs2_fwd = ex_mem_q.result;
			rv_pkg::FWD_WB:  rs2_fwd = wb_data;
			default:         rs2_fwd = id_ex_q.rdata2;
		endcase
	end

	// Forwarded rs2 also feeds store data
	assign opnd_b = id_ex_q.ctrl.use_imm ? id_ex_q.imm : rs2_fwd;

	rv_alu i_alu
	(
		.i_op      (id_ex_q.ctrl.alu_op),
		.i_a       (opnd_a),
		.i_b       (opnd_b),
		.i_pc      (id_ex_q.pc),
		.i_imm     (id_ex_q.imm),
		.i_br_kind (id_ex_q.ctrl.br_kind),
		.o_result  (alu_result),
		.o_taken   (taken),
		.o_target  (target)
	);

	assign ex_mem_d = '{result: alu_result, store_data: rs2_fwd, rd: id_ex_q.rd,
		ctrl: id_ex_q.ctrl};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ex_mem_q <= rv_pkg::EX_MEM_NOP;
		else if (!i_halt)
			ex_mem_q <= ex_mem_d;
	end

	// ==============================
	// Memory
	// ==============================
	assign dmem.re          = ex_mem_q.ctrl.mem_re;
	// No store while frozen
	assign dmem.we          = ex_mem_q.ctrl.mem_we && !i_halt;
	assign dmem.size        = ex_mem_q.ctrl.mem_size;
	assign dmem.is_unsigned = ex_mem_q.ctrl.load_uns;
	assign dmem.addr        = ex_mem_q.result;
	assign dmem.wdata       = ex_mem_q.store_data;

	assign mem_wb_d = '{result: ex_mem_q.result, load_data: dmem.rdata, rd: ex_mem_q.rd,
		ctrl: ex_mem_q.ctrl};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mem_wb_q <= rv_pkg::MEM_WB_NOP;
		else if (!i_halt)
			mem_wb_q <= mem_wb_d;
	end

	// ==============================
	// Write-back
	// ==============================
	assign wb_we   = mem_wb_q.ctrl.reg_we && !i_halt;
	assign wb_data = mem_wb_q.ctrl.wb_mem ? mem_wb_q.load_data : mem_wb_q.result;

	// One strobe per retired write to a real register
	assign o_wb_valid = wb_we && (mem_wb_q.rd != 5'd0);
	assign o_wb_rd    = mem_wb_q.rd;
	assign o_wb_data  = wb_data;

endmodule

// File: core/rv_hazard.sv
`timescale 1ns/1ns

module rv_hazard
(
	input  logic [4:0]       i_id_rs1,
	input  logic [4:0]       i_id_rs2,
	input  logic [4:0]       i_ex_rs1,
	input  logic [4:0]       i_ex_rs2,
	input  logic [4:0]       i_ex_rd,
	input  logic             i_ex_load,
	input  logic [4:0]       i_mem_rd,
	input  logic             i_mem_we,
	input  logic [4:0]       i_wb_rd,
	input  logic             i_wb_we,
	input  logic             i_taken,
	output rv_pkg::fwd_sel_e o_fwd_a,
	output rv_pkg::fwd_sel_e o_fwd_b,
	output logic             o_stall,
	output logic             o_flush
);

	logic load_use;

	// Youngest producer first, x0 never forwarded
	function automatic rv_pkg::fwd_sel_e fwd_pick
	(
		input logic [4:0] rs,
		input logic [4:0] mem_rd,
		input logic       mem_we,
		input logic [4:0] wb_rd,
		input logic       wb_we
	);
		if (rs != 5'd0 && mem_we && mem_rd == rs)
			return rv_pkg::FWD_MEM;
		else if (rs != 5'd0 && wb_we && wb_rd == rs)
			return rv_pkg::FWD_WB;
		else
			return rv_pkg::FWD_RF;
	endfunction

	assign o_fwd_a = fwd_pick(i_ex_rs1, i_mem_rd, i_mem_we, i_wb_rd, i_wb_we);
	assign o_fwd_b = fwd_pick(i_ex_rs2, i_mem_rd, i_mem_we, i_wb_rd, i_wb_we);

	// Load in execute feeding decode
	assign load_use = i_ex_load && (i_ex_rd != 5'd0)
		&& (i_ex_rd == i_id_rs1 || i_ex_rd == i_id_rs2);

	// Redirect outranks the stall, decode is wrong path anyway
	assign o_flush = i_taken;
	assign o_stall = load_use && !i_taken;

endmodule

// File: core/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [4:0]              i_rs1,
	input  logic [4:0]              i_rs2,
	input  logic                    i_we,
	input  logic [4:0]              i_rd,
	input  logic [rv_pkg::XLEN-1:0] i_wdata,
	output logic [rv_pkg::XLEN-1:0] o_rdata1,
	output logic [rv_pkg::XLEN-1:0] o_rdata2
);

	// x0 has no storage
	logic [rv_pkg::XLEN-1:0] regs [1:31];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (i_we && i_rd != 5'd0)
			regs[i_rd] <= i_wdata;
	end

	// Same-cycle write seen by the reader
	assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : (i_we && i_rd == i_rs1) ? i_wdata : regs[i_rs1];
	assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : (i_we && i_rd == i_rs2) ? i_wdata : regs[i_rs2];

endmodule

// File: core/rv_alu.sv
`timescale 1ns/1ns

module rv_alu
(
	input  rv_pkg::alu_op_e         i_op,
	input  logic [rv_pkg::XLEN-1:0] i_a,
	input  logic [rv_pkg::XLEN-1:0] i_b,
	input  logic [rv_pkg::XLEN-1:0] i_pc,
	input  logic [rv_pkg::XLEN-1:0] i_imm,
	input  rv_pkg::br_kind_e        i_br_kind,
	output logic [rv_pkg::XLEN-1:0] o_result,
	output logic                    o_taken,
	output logic [rv_pkg::XLEN-1:0] o_target
);

	logic                    equal;
	logic                    less;
	logic [rv_pkg::XLEN-1:0] op_result;

	// Shared by SLT and the branch compares
	assign equal = (i_a == i_b);
	assign less  = $signed(i_a) < $signed(i_b);

	always_comb
	begin
		case (i_op)
			rv_pkg::ALU_SUB:    op_result = i_a - i_b;
			rv_pkg::ALU_AND:    op_result = i_a & i_b;
			rv_pkg::ALU_OR:     op_result = i_a | i_b;
			rv_pkg::ALU_XOR:    op_result = i_a ^ i_b;
			rv_pkg::ALU_SLT:    op_result = {{(rv_pkg::XLEN-1){1'b0}}, less};
			rv_pkg::ALU_PASS_B: op_result = i_b;
			default:            op_result = i_a + i_b;
		endcase
	end

	always_comb
	begin
		case (i_br_kind)
			rv_pkg::BR_BEQ: o_taken = equal;
			rv_pkg::BR_BNE: o_taken = !equal;
			rv_pkg::BR_BLT: o_taken = less;
			rv_pkg::BR_BGE: o_taken = !less;
			rv_pkg::BR_JAL: o_taken = 1'b1;
			default:        o_taken = 1'b0;
		endcase
	end

	// Link address for JAL
	assign o_result = (i_br_kind == rv_pkg::BR_JAL) ? i_pc + rv_pkg::INST_BYTES : op_result;
	assign o_target = i_pc + i_imm;

endmodule

// File: core/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder
(
	input  logic [rv_pkg::XLEN-1:0] i_inst,
	output logic [4:0]              o_rs1,
	output logic [4:0]              o_rs2,
	output logic [4:0]              o_rd,
	output logic [rv_pkg::XLEN-1:0] o_imm,
	output rv_pkg::ctrl_t           o_ctrl
);

	logic [6:0]              opcode;
	logic [2:0]              funct3;
	logic [6:0]              funct7;
	logic                    use_rs1;
	logic                    use_rs2;
	logic [rv_pkg::XLEN-1:0] imm_i;
	logic [rv_pkg::XLEN-1:0] imm_s;
	logic [rv_pkg::XLEN-1:0] imm_b;
	logic [rv_pkg::XLEN-1:0] imm_u;
	logic [rv_pkg::XLEN-1:0] imm_j;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	// Immediate formats, all sign-extended from bit 31
	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_u = {i_inst[31:12], 12'b0};
	assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

	always_comb
	begin
		o_ctrl  = rv_pkg::CTRL_NOP;
		o_imm   = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			rv_pkg::OP_REG:
			begin
				use_rs1        = 1'b1;
				use_rs2        = 1'b1;
				o_ctrl.use_imm = 1'b0;
				// SUB is the only funct7 variant taken
				if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000))
				begin
					o_ctrl.reg_we = 1'b1;
					case (funct3)
						3'b000:
							if (funct7[5])
								o_ctrl.alu_op = rv_pkg::ALU_SUB;
						3'b010:  o_ctrl.alu_op = rv_pkg::ALU_SLT;
						3'b100:  o_ctrl.alu_op = rv_pkg::ALU_XOR;
						3'b110:  o_ctrl.alu_op = rv_pkg::ALU_OR;
						3'b111:  o_ctrl.alu_op = rv_pkg::ALU_AND;
						default: o_ctrl.reg_we = 1'b0;
					endcase
				end
			end
			rv_pkg::OP_IMM:
			begin
				use_rs1       = 1'b1;
				o_imm         = imm_i;
				o_ctrl.reg_we = 1'b1;
				case (funct3)
					3'b000:  o_ctrl.alu_op = rv_pkg::ALU_ADD;
					3'b100:  o_ctrl.alu_op = rv_pkg::ALU_XOR;
					3'b110:  o_ctrl.alu_op = rv_pkg::ALU_OR;
					3'b111:  o_ctrl.alu_op = rv_pkg::ALU_AND;
					default: o_ctrl.reg_we = 1'b0;
				endcase
			end
			rv_pkg::OP_LUI:
			begin
				o_imm         = imm_u;
				o_ctrl.alu_op = rv_pkg::ALU_PASS_B;
				o_ctrl.reg_we = 1'b1;
			end
			rv_pkg::OP_LOAD:
			begin
				use_rs1 = 1'b1;
				o_imm   = imm_i;
				// LW, LB, LBU
				if (funct3 == 3'b010 || funct3 == 3'b000 || funct3 == 3'b100)
				begin
					o_ctrl.reg_we   = 1'b1;
					o_ctrl.mem_re   = 1'b1;
					o_ctrl.wb_mem   = 1'b1;
					o_ctrl.load_uns = funct3[2];
					if (funct3 != 3'b010)
						o_ctrl.mem_size = rv_pkg::SZ_BYTE;
				end
			end
			rv_pkg::OP_STORE:
			begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				o_imm   = imm_s;
				if (funct3 == 3'b010 || funct3 == 3'b000)
				begin
					o_ctrl.mem_we = 1'b1;
					if (funct3 == 3'b000)
						o_ctrl.mem_size = rv_pkg::SZ_BYTE;
				end
			end
			rv_pkg::OP_BRANCH:
			begin
				use_rs1        = 1'b1;
				use_rs2        = 1'b1;
				o_imm          = imm_b;
				// Compare rs1 against rs2
				o_ctrl.use_imm = 1'b0;
				case (funct3)
					3'b000:  o_ctrl.br_kind = rv_pkg::BR_BEQ;
					3'b001:  o_ctrl.br_kind = rv_pkg::BR_BNE;
					3'b100:  o_ctrl.br_kind = rv_pkg::BR_BLT;
					3'b101:  o_ctrl.br_kind = rv_pkg::BR_BGE;
					default: o_ctrl.br_kind = rv_pkg::BR_NONE;
				endcase
			end
			rv_pkg::OP_JAL:
			begin
				o_imm          = imm_j;
				o_ctrl.br_kind = rv_pkg::BR_JAL;
				o_ctrl.reg_we  = 1'b1;
			end
			default:
				o_ctrl = rv_pkg::CTRL_NOP;
		endcase
	end

	// Unused fields read as x0 so hazards see nothing
	assign o_rs1 = use_rs1 ? i_inst[19:15] : 5'd0;
	assign o_rs2 = use_rs2 ? i_inst[24:20] : 5'd0;
	assign o_rd  = o_ctrl.reg_we ? i_inst[11:7] : 5'd0;

endmodule

// File: common/dmem_if.sv
`timescale 1ns/1ns

interface dmem_if;

	// Request side, driven by the memory stage
	logic                    re;
	logic                    we;
	rv_pkg::mem_size_e       size;
	logic                    is_unsigned;
	logic [rv_pkg::XLEN-1:0] addr;
	logic [rv_pkg::XLEN-1:0] wdata;
	// Load data, same cycle as the request
	logic [rv_pkg::XLEN-1:0] rdata;

	modport core
	(
		output re, we, size, is_unsigned, addr, wdata,
		input  rdata
	);

	modport mem
	(
		input  re, we, size, is_unsigned, addr, wdata,
		output rdata
	);

endinterface

// File: common/rv_pkg.sv
package rv_pkg;

	// ==============================
	// Widths and depths
	// ==============================
	localparam int XLEN       = 32;
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	// Word address widths
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

	localparam logic [XLEN-1:0] RESET_PC   = '0;
	localparam logic [XLEN-1:0] INST_BYTES = 4;
	// ADDI x0,x0,0
	localparam logic [XLEN-1:0] NOP_INST   = 32'h0000_0013;

	// Major opcodes
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;

	// ==============================
	// Control encodings
	// ==============================
	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_PASS_B} alu_op_e;
	typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_JAL} br_kind_e;
	typedef enum logic {SZ_BYTE, SZ_WORD} mem_size_e;
	typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		br_kind_e  br_kind;
		// Operand B from immediate instead of rs2
		logic      use_imm;
		logic      reg_we;
		logic      mem_re;
		logic      mem_we;
		mem_size_e mem_size;
		logic      load_uns;
		// Write-back takes load data
		logic      wb_mem;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '{alu_op: ALU_ADD, br_kind: BR_NONE, use_imm: 1'b1,
		reg_we: 1'b0, mem_re: 1'b0, mem_we: 1'b0, mem_size: SZ_WORD, load_uns: 1'b0,
		wb_mem: 1'b0};

	// ==============================
	// Stage register payloads
	// ==============================
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] inst;
	} if_id_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [XLEN-1:0] rdata1;
		logic [XLEN-1:0] rdata2;
		logic [XLEN-1:0] imm;
		ctrl_t           ctrl;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
		logic [4:0]      rd;
		ctrl_t           ctrl;
	} ex_mem_t;

	typedef struct packed {
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] load_data;
		logic [4:0]      rd;
		ctrl_t           ctrl;
	} mem_wb_t;

	// Bubble contents for reset and flush
	localparam if_id_t  IF_ID_NOP  = '{pc: RESET_PC, inst: NOP_INST};
	localparam id_ex_t  ID_EX_NOP  = '{ctrl: CTRL_NOP, default: '0};
	localparam ex_mem_t EX_MEM_NOP = '{ctrl: CTRL_NOP, default: '0};
	localparam mem_wb_t MEM_WB_NOP = '{ctrl: CTRL_NOP, default: '0};

endpackage
